//--- verilog/imuldiv_settings.svh
//--------------------
// imuldiv settings
// operand, tag and iteration sizes
//--------------------

`ifndef IMULDIV_SETTINGS_SVH
`define IMULDIV_SETTINGS_SVH

// operand width, result is twice this
`define IMULDIV_XLEN 32

// request tag width
`define IMULDIV_TAG_BITS 4

// one iteration per operand bit
`define IMULDIV_ITERS `IMULDIV_XLEN

`endif

//--- verilog/imuldiv_pkg.sv
//--------------------
// imuldiv package
// function codes, request and response structs
//--------------------

`default_nettype none

`include "imuldiv_settings.svh"

package imuldiv_pkg;

  // function code carried in each request
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_MULU = 2'd1,
    FN_DIV  = 2'd2,
    FN_DIVU = 2'd3
  } muldiv_fn_e;

  // control states shared by both iterative units
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } unit_state_e;

  // request: fn, tag, operand a, operand b (70 bits)
  typedef struct packed {
    muldiv_fn_e                   fn;
    logic [`IMULDIV_TAG_BITS-1:0] tag;
    logic [`IMULDIV_XLEN-1:0]     a;
    logic [`IMULDIV_XLEN-1:0]     b;
  } muldiv_req_t;

  // response: tag and double-width result (68 bits)
  typedef struct packed {
    logic [`IMULDIV_TAG_BITS-1:0] tag;
    logic [2*`IMULDIV_XLEN-1:0]   result;
  } muldiv_resp_t;

endpackage

`default_nettype wire

//--- verilog/imuldiv_req_dispatch.sv
//--------------------
// request dispatcher
// steers each request to the multiplier or the divider
//--------------------

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_req_dispatch (
  input  wire imuldiv_pkg::muldiv_req_t  req,
  input  wire logic                      req_val,
  output logic                           req_rdy,
  output logic                           mul_val,
  output logic                           div_val,
  input  wire logic                      mul_rdy,
  input  wire logic                      div_rdy,
  output logic [`IMULDIV_XLEN-1:0]       op_a,
  output logic [`IMULDIV_XLEN-1:0]       op_b,
  output logic                           op_signed,
  output logic [`IMULDIV_TAG_BITS-1:0]   op_tag
);

  // divide class when fn is DIV or DIVU
  logic is_div;

  assign is_div = (req.fn == imuldiv_pkg::FN_DIV) || (req.fn == imuldiv_pkg::FN_DIVU);

  // signed variants of both classes
  assign op_signed = (req.fn == imuldiv_pkg::FN_MUL) || (req.fn == imuldiv_pkg::FN_DIV);

  // only the target unit sees val
  assign mul_val = req_val & ~is_div;
  assign div_val = req_val & is_div;

  // busy unit blocks only its own class
  assign req_rdy = is_div ? div_rdy : mul_rdy;

  // payload fans out to both units
  assign op_a   = req.a;
  assign op_b   = req.b;
  assign op_tag = req.tag;

endmodule

`default_nettype wire

//--- verilog/imuldiv_int_mul_iterative.sv
//--------------------
// iterative multiplier
// signed/unsigned shift-add, one bit per cycle
//--------------------

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_int_mul_iterative (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic [`IMULDIV_XLEN-1:0]    a,
  input  wire logic [`IMULDIV_XLEN-1:0]    b,
  input  wire logic                        op_signed,
  input  wire logic [`IMULDIV_TAG_BITS-1:0] tag,
  input  wire logic                        req_val,
  output logic                             req_rdy,
  output imuldiv_pkg::muldiv_resp_t        resp,
  output logic                             resp_val,
  input  wire logic                        resp_rdy
);

  localparam int XLEN  = `IMULDIV_XLEN;
  localparam int CNT_W = $clog2(`IMULDIV_ITERS);

  imuldiv_pkg::unit_state_e state_q;
  logic [CNT_W-1:0]         count_q;

  // datapath registers
  logic [2*XLEN-1:0]            mcand_q;
  logic [XLEN-1:0]              mplier_q;
  logic [2*XLEN-1:0]            prod_q;
  logic                         sign_a_q;
  logic                         sign_b_q;
  logic [`IMULDIV_TAG_BITS-1:0] tag_q;

  logic            accept;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  //--------------------
  // handshake
  //--------------------

  assign req_rdy  = (state_q == imuldiv_pkg::ST_IDLE);
  assign resp_val = (state_q == imuldiv_pkg::ST_DONE);
  assign accept   = req_val & req_rdy;

  // sign only counts for the signed variant
  assign a_neg = op_signed & a[XLEN-1];
  assign b_neg = op_signed & b[XLEN-1];
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  //--------------------
  // control FSM
  //--------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= imuldiv_pkg::ST_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        imuldiv_pkg::ST_IDLE: begin
          if (accept) begin
            state_q <= imuldiv_pkg::ST_CALC;
            count_q <= '0;
          end
        end
        imuldiv_pkg::ST_CALC: begin
          // last iteration moves to done
          if (count_q == CNT_W'(`IMULDIV_ITERS - 1)) begin
            state_q <= imuldiv_pkg::ST_DONE;
          end
          count_q <= count_q + 1'b1;
        end
        imuldiv_pkg::ST_DONE: begin
          if (resp_rdy) begin
            state_q <= imuldiv_pkg::ST_IDLE;
          end
        end
        default: state_q <= imuldiv_pkg::ST_IDLE;
      endcase
    end
  end

  //--------------------
  // datapath
  //--------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      // load magnitudes, clear the product
      mcand_q  <= {{XLEN{1'b0}}, a_mag};
      mplier_q <= b_mag;
      prod_q   <= '0;
      sign_a_q <= a_neg;
      sign_b_q <= b_neg;
      tag_q    <= tag;
    end else if (state_q == imuldiv_pkg::ST_CALC) begin
      // add shifted multiplicand on a set multiplier bit
      if (mplier_q[0]) begin
        prod_q <= prod_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // product sign fixed up on the way out
  always_comb begin
    resp.tag    = tag_q;
    resp.result = (sign_a_q ^ sign_b_q) ? (~prod_q + 1'b1) : prod_q;
  end

  // held response must not move under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp))
    else $error("multiplier response changed while stalled");

endmodule

`default_nettype wire

//--- verilog/imuldiv_int_div_iterative.sv
//--------------------
// iterative divider
// signed/unsigned restoring division on magnitudes
//--------------------

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_int_div_iterative (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic [`IMULDIV_XLEN-1:0]    a,
  input  wire logic [`IMULDIV_XLEN-1:0]    b,
  input  wire logic                        op_signed,
  input  wire logic [`IMULDIV_TAG_BITS-1:0] tag,
  input  wire logic                        req_val,
  output logic                             req_rdy,
  output imuldiv_pkg::muldiv_resp_t        resp,
  output logic                             resp_val,
  input  wire logic                        resp_rdy
);

  localparam int XLEN  = `IMULDIV_XLEN;
  localparam int CNT_W = $clog2(`IMULDIV_ITERS);

  imuldiv_pkg::unit_state_e state_q;
  logic [CNT_W-1:0]         count_q;

  // remainder and quotient shift as one register pair
  logic [XLEN-1:0]              rem_q;
  logic [XLEN-1:0]              quo_q;
  logic [XLEN-1:0]              dvs_q;
  logic                         dvd_neg_q;
  logic                         dvs_neg_q;
  logic [`IMULDIV_TAG_BITS-1:0] tag_q;

  logic            accept;
  logic            dvd_neg;
  logic            dvs_neg;
  logic [XLEN-1:0] dvd_mag;
  logic [XLEN-1:0] dvs_mag;

  // one restoring step
  logic [XLEN:0]   rem_shift;
  logic [XLEN+1:0] diff;
  logic            diff_neg;

  // output fix-up
  logic            quo_fix;
  logic [XLEN-1:0] quo_out;
  logic [XLEN-1:0] rem_out;

  //--------------------
  // handshake
  //--------------------

  assign req_rdy  = (state_q == imuldiv_pkg::ST_IDLE);
  assign resp_val = (state_q == imuldiv_pkg::ST_DONE);
  assign accept   = req_val & req_rdy;

  assign dvd_neg = op_signed & a[XLEN-1];
  assign dvs_neg = op_signed & b[XLEN-1];
  assign dvd_mag = dvd_neg ? (~a + 1'b1) : a;
  assign dvs_mag = dvs_neg ? (~b + 1'b1) : b;

  //--------------------
  // control FSM
  //--------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= imuldiv_pkg::ST_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        imuldiv_pkg::ST_IDLE: begin
          if (accept) begin
            state_q <= imuldiv_pkg::ST_CALC;
            count_q <= '0;
          end
        end
        imuldiv_pkg::ST_CALC: begin
          if (count_q == CNT_W'(`IMULDIV_ITERS - 1)) begin
            state_q <= imuldiv_pkg::ST_DONE;
          end
          count_q <= count_q + 1'b1;
        end
        imuldiv_pkg::ST_DONE: begin
          if (resp_rdy) begin
            state_q <= imuldiv_pkg::ST_IDLE;
          end
        end
        default: state_q <= imuldiv_pkg::ST_IDLE;
      endcase
    end
  end

  //--------------------
  // datapath
  //--------------------

  // next dividend bit enters the remainder, then trial subtract
  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign diff      = {1'b0, rem_shift} - {2'b00, dvs_q};
  assign diff_neg  = diff[XLEN+1];

  always_ff @(posedge clk) begin
    if (accept) begin
      // dividend starts in the quotient half
      rem_q     <= '0;
      quo_q     <= dvd_mag;
      dvs_q     <= dvs_mag;
      dvd_neg_q <= dvd_neg;
      dvs_neg_q <= dvs_neg;
      tag_q     <= tag;
    end else if (state_q == imuldiv_pkg::ST_CALC) begin
      if (diff_neg) begin
        // restore and shift in a zero quotient bit
        rem_q <= rem_shift[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end else begin
        rem_q <= diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end
    end
  end

  // a zero divisor keeps the all-ones quotient unsigned
  assign quo_fix = (dvd_neg_q ^ dvs_neg_q) & (|dvs_q);
  assign quo_out = quo_fix ? (~quo_q + 1'b1) : quo_q;

  // remainder follows the dividend sign
  assign rem_out = dvd_neg_q ? (~rem_q + 1'b1) : rem_q;

  always_comb begin
    resp.tag    = tag_q;
    resp.result = {rem_out, quo_out};
  end

  // result offered one cycle after the last calc step
  assert property (@(posedge clk) disable iff (reset)
    accept |-> ##(`IMULDIV_ITERS + 1) resp_val)
    else $error("divider result missing after the calc phase");

endmodule

`default_nettype wire

//--- verilog/imuldiv_resp_arbiter.sv
//--------------------
// response arbiter
// round-robin merge of two response streams
//--------------------

`timescale 1ns/1ps
`default_nettype none

module imuldiv_resp_arbiter #(
  parameter type payload_t = imuldiv_pkg::muldiv_resp_t
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire payload_t in_payload [2],
  input  wire logic [1:0] in_val,
  output logic [1:0]    in_rdy,
  output payload_t      out_payload,
  output logic          out_val,
  input  wire logic     out_rdy
);

  // priority pointer, held grant, current select
  logic prio_q;
  logic lock_q;
  logic grant_q;
  logic sel;

  // priority input first and the other one otherwise
  always_comb begin
    if (lock_q) begin
      sel = grant_q;
    end else if (in_val[prio_q]) begin
      sel = prio_q;
    end else if (in_val[~prio_q]) begin
      sel = ~prio_q;
    end else begin
      sel = prio_q;
    end
  end

  assign out_val     = in_val[sel];
  assign out_payload = in_payload[sel];
  assign in_rdy      = out_rdy ? (2'b01 << sel) : 2'b00;

  always_ff @(posedge clk) begin
    if (reset) begin
      prio_q  <= 1'b0;
      lock_q  <= 1'b0;
      grant_q <= 1'b0;
    end else begin
      // stalled output keeps its source
      lock_q  <= out_val & ~out_rdy;
      grant_q <= sel;
      // winner drops to lowest priority after a transfer
      if (out_val && out_rdy) begin
        prio_q <= ~sel;
      end
    end
  end

  // stalled output must keep the same payload until it moves
  assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(out_payload))
    else $error("arbiter output changed while stalled");

endmodule

`default_nettype wire

//--- verilog/imuldiv_top.sv
//--------------------
// imuldiv top
// dispatcher, multiplier, divider and response arbiter
//--------------------

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_top (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire imuldiv_pkg::muldiv_req_t  req,
  input  wire logic                      req_val,
  output logic                           req_rdy,
  output imuldiv_pkg::muldiv_resp_t      resp,
  output logic                           resp_val,
  input  wire logic                      resp_rdy
);

  // shared operand bus from the dispatcher
  logic [`IMULDIV_XLEN-1:0]     op_a;
  logic [`IMULDIV_XLEN-1:0]     op_b;
  logic                         op_signed;
  logic [`IMULDIV_TAG_BITS-1:0] op_tag;
  logic                         mul_val;
  logic                         div_val;
  logic                         mul_rdy;
  logic                         div_rdy;

  // unit responses, index 0 multiplier, 1 divider
  imuldiv_pkg::muldiv_resp_t unit_resp [2];
  logic [1:0]                unit_val;
  logic [1:0]                unit_rdy;

  imuldiv_req_dispatch u_dispatch (
    .req, .req_val, .req_rdy,
    .mul_val, .div_val, .mul_rdy, .div_rdy,
    .op_a, .op_b, .op_signed, .op_tag
  );

  imuldiv_int_mul_iterative u_mul (
    .clk, .reset,
    .a(op_a), .b(op_b), .op_signed, .tag(op_tag),
    .req_val(mul_val), .req_rdy(mul_rdy),
    .resp(unit_resp[0]), .resp_val(unit_val[0]), .resp_rdy(unit_rdy[0])
  );

  imuldiv_int_div_iterative u_div (
    .clk, .reset,
    .a(op_a), .b(op_b), .op_signed, .tag(op_tag),
    .req_val(div_val), .req_rdy(div_rdy),
    .resp(unit_resp[1]), .resp_val(unit_val[1]), .resp_rdy(unit_rdy[1])
  );

  imuldiv_resp_arbiter #(
    .payload_t(imuldiv_pkg::muldiv_resp_t)
  ) u_arb (
    .clk, .reset,
    .in_payload(unit_resp), .in_val(unit_val), .in_rdy(unit_rdy),
    .out_payload(resp), .out_val(resp_val), .out_rdy(resp_rdy)
  );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
//--------------------
// testbench clock and reset
//--------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset held over the first rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- tests/imuldiv_tb.sv
//--------------------
// imuldiv testbench
// random requests, tag scoreboard, assertion checks
//--------------------

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_tb;

  localparam int NUM_OPS     = 300;
  localparam int CYCLE_LIMIT = NUM_OPS * 80;
  localparam int TAGS        = 1 << `IMULDIV_TAG_BITS;

  logic                      clk;
  logic                      reset;
  imuldiv_pkg::muldiv_req_t  req;
  logic                      req_val;
  logic                      req_rdy;
  imuldiv_pkg::muldiv_resp_t resp;
  logic                      resp_val;
  logic                      resp_rdy;

  // scoreboard indexed by tag
  logic [2*`IMULDIV_XLEN-1:0]   expected [TAGS];
  logic [TAGS-1:0]              outstanding = '0;
  logic [`IMULDIV_TAG_BITS-1:0] free_tags [$];

  int seed = 15450;
  int issued = 0;
  int accepted = 0;
  int cross_accepts = 0;
  int cycles = 0;
  int value_errors = 0;
  int tag_errors = 0;
  int protocol_errors = 0;
  int total_errors;
  logic req_fire = 1'b0;

  tb_clock_gen u_clock (.clk, .reset);

  imuldiv_top DUT (.clk, .reset, .req, .req_val, .req_rdy, .resp, .resp_val, .resp_rdy);

  //--------------------
  // reference model
  //--------------------

  function automatic logic [2*`IMULDIV_XLEN-1:0] model_result(imuldiv_pkg::muldiv_fn_e fn,
                                                               logic [31:0] a, logic [31:0] b);
    logic signed [63:0] wa;
    logic signed [63:0] wb;
    logic signed [31:0] na;
    logic signed [31:0] nb;
    wa = {{32{a[31]}}, a};
    wb = {{32{b[31]}}, b};
    na = a;
    nb = b;
    case (fn)
      imuldiv_pkg::FN_MUL:  return wa * wb;
      imuldiv_pkg::FN_MULU: return {32'd0, a} * {32'd0, b};
      imuldiv_pkg::FN_DIV: begin
        // remainder in the high half and quotient in the low half
        // zero divisor and overflow handled first
        if (b == 32'd0) return {a, 32'hffff_ffff};
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) return {32'd0, a};
        return {32'(na % nb), 32'(na / nb)};
      end
      default: begin
        if (b == 32'd0) return {a, 32'hffff_ffff};
        return {a % b, a / b};
      end
    endcase
  endfunction

  // zero, one, minus one, most negative
  function automatic logic [31:0] corner_value(logic [1:0] idx);
    case (idx)
      2'd0:    return 32'h0000_0000;
      2'd1:    return 32'h0000_0001;
      2'd2:    return 32'hffff_ffff;
      default: return 32'h8000_0000;
    endcase
  endfunction

  task automatic random_operand(output logic [31:0] v);
    int unsigned kind;
    kind = $unsigned($random(seed)) % 4;
    case (kind)
      0:       v = corner_value(2'($random(seed)));
      1:       v = 32'($random(seed)) & 32'h0000_00ff;
      default: v = $random(seed);
    endcase
  endtask

  // first 64 requests walk every corner pair for every fn
  task automatic issue_request();
    imuldiv_pkg::muldiv_req_t r;
    logic [31:0] a;
    logic [31:0] b;
    if (issued < 64) begin
      r.fn = imuldiv_pkg::muldiv_fn_e'(issued[5:4]);
      a = corner_value(issued[3:2]);
      b = corner_value(issued[1:0]);
    end else begin
      r.fn = imuldiv_pkg::muldiv_fn_e'(2'($random(seed)));
      random_operand(a);
      random_operand(b);
    end
    r.a = a;
    r.b = b;
    r.tag = free_tags.pop_front();
    expected[r.tag] = model_result(r.fn, a, b);
    req = r;
    req_val = 1'b1;
    issued++;
  endtask

  //--------------------
  // monitor
  //--------------------

  // transfers happen on the rising edge
  always @(posedge clk) begin
    req_fire = !reset && req_val && req_rdy;
    if (req_fire) begin
      outstanding[req.tag] <= 1'b1;
      accepted++;
      // divide taken while the multiplier still works
      if ((req.fn == imuldiv_pkg::FN_DIV || req.fn == imuldiv_pkg::FN_DIVU) && !DUT.mul_rdy)
        cross_accepts++;
    end
    if (!reset && resp_val && resp_rdy && outstanding[resp.tag]) begin
      outstanding[resp.tag] <= 1'b0;
      free_tags.push_back(resp.tag);
    end
  end

  //--------------------
  // checks
  //--------------------

  assert property (@(posedge clk) $fell(reset) |-> !resp_val && req_rdy)
    else begin
      value_errors++;
      $display("CHECK FAILED reset: resp_val expected 0 actual %h, req_rdy expected 1 actual %h",
               $sampled(resp_val), $sampled(req_rdy));
    end

  assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> outstanding[resp.tag])
    else begin
      tag_errors++;
      $display("response tag %h arrived while that tag was not outstanding", $sampled(resp.tag));
    end

  assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy && outstanding[resp.tag] |-> resp.result == expected[resp.tag])
    else begin
      value_errors++;
      $display("CHECK FAILED resp.result tag %h: expected %h actual %h", $sampled(resp.tag),
               expected[$sampled(resp.tag)], $sampled(resp.result));
    end

  // stalled response holds its payload
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp))
    else begin
      protocol_errors++;
      $display("response dropped or changed while the bus was stalled");
    end

  //--------------------
  // stimulus
  //--------------------

  initial begin
    req = '0;
    req_val = 1'b0;
    resp_rdy = 1'b0;
    for (int t = 0; t < TAGS; t++) begin
      free_tags.push_back(t[`IMULDIV_TAG_BITS-1:0]);
    end
    @(negedge reset);
    while (accepted < NUM_OPS || outstanding != '0) begin
      @(negedge clk);
      resp_rdy = ($unsigned($random(seed)) % 10) < 7;
      if (req_val && req_fire) req_val = 1'b0;
      if (!req_val && issued < NUM_OPS && free_tags.size() > 0) issue_request();
    end
    @(negedge clk);
    assert (cross_accepts > 0)
      else begin
        protocol_errors++;
        $display("no divide was accepted while the multiplier was busy");
      end
    total_errors = value_errors + tag_errors + protocol_errors;
    $display("summary: %0d requests, value errors %0d, tag errors %0d, protocol errors %0d",
             accepted, value_errors, tag_errors, protocol_errors);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // run limit
  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with tags %h still outstanding", cycles, outstanding);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/imuldiv_pkg.sv
verilog/imuldiv_req_dispatch.sv
verilog/imuldiv_int_mul_iterative.sv
verilog/imuldiv_int_div_iterative.sv
verilog/imuldiv_resp_arbiter.sv
verilog/imuldiv_top.sv
tests/tb_clock_gen.sv
tests/imuldiv_tb.sv

//--- Makefile
# Verilator build and run of the imuldiv testbench

SRCS := $(shell grep -v '^+' sim.f) verilog/imuldiv_settings.svh

.PHONY: all run clean

all: run

# binary is rebuilt only when a source or the file list changes
obj_dir/sim_imuldiv: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module imuldiv_tb \
	  -Mdir obj_dir -o sim_imuldiv

run: obj_dir/sim_imuldiv
	./obj_dir/sim_imuldiv > sim.log 2>&1; cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
